//--- hdl/cpuPkg.sv
package cpuPkg;

    localparam int busAddrWidth = 16;
    localparam int busDataWidth = 8;

    // Opcodes recognised as whole bytes
    localparam logic [7:0] brkOpcode    = 8'h00;
    localparam logic [7:0] jmpAbsOpcode = 8'h4C;

    // 6502 layout aaabbbcc
    typedef struct packed {
        logic [2:0] aaa;
        logic [2:0] bbb;
        logic [1:0] cc;
    } opcodeFields;

    typedef union packed {
        logic [7:0]  whole;
        opcodeFields field;
    } opcodeWord;

    typedef enum logic [3:0] {
        opOra,
        opAnd,
        opEor,
        opAdc,
        opSta,
        opLda,
        opJmp,
        opBrk,
        opNop
    } aluOp;

    typedef enum logic [1:0] {
        modeImplied,
        modeImmediate,
        modeAbsolute
    } addrMode;

endpackage

//--- hdl/memBusIf.sv
`timescale 1ns/1ps

interface memBusIf import cpuPkg::*; ();

    logic                    request;
    logic                    write;
    logic [busAddrWidth-1:0] addr;
    logic [busDataWidth-1:0] wdata;
    logic                    grant;
    logic [busDataWidth-1:0] rdata;

    modport requester (
        output request, write, addr, wdata,
        input  grant, rdata
    );

    modport arbiter (
        input  request, write, addr, wdata,
        output grant, rdata
    );

endinterface

//--- hdl/instructionDecoder.sv
`timescale 1ns/1ps

module instructionDecoder import cpuPkg::*; (
    input  opcodeWord opcode,
    output aluOp      operation,
    output addrMode   mode
);

    always_comb begin
        operation = opNop;
        mode      = modeImplied;

        if (opcode.whole == brkOpcode) begin
            operation = opBrk;
        end else if (opcode.whole == jmpAbsOpcode) begin
            operation = opJmp;
            mode      = modeAbsolute;
        end else if (opcode.field.cc == 2'b01 &&
                     (opcode.field.bbb == 3'b010 || opcode.field.bbb == 3'b011)) begin
            mode = (opcode.field.bbb == 3'b010) ? modeImmediate : modeAbsolute;
            case (opcode.field.aaa)
                3'b000: operation = opOra;
                3'b001: operation = opAnd;
                3'b010: operation = opEor;
                3'b011: operation = opAdc;
                3'b100: begin
                    // No store to an immediate
                    if (mode == modeAbsolute) begin
                        operation = opSta;
                    end else begin
                        mode = modeImplied;
                    end
                end
                3'b101: operation = opLda;
                default: begin
                    // CMP and SBC are outside the subset
                    operation = opNop;
                    mode      = modeImplied;
                end
            endcase
        end
    end

endmodule

//--- hdl/cpuCore.sv
`timescale 1ns/1ps

module cpuCore import cpuPkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         enable,
    memBusIf.requester   bus,
    output logic         halted
);

    localparam logic [2:0] stFetch       = 3'd0;
    localparam logic [2:0] stOperandLow  = 3'd1;
    localparam logic [2:0] stOperandHigh = 3'd2;
    localparam logic [2:0] stDataRead    = 3'd3;
    localparam logic [2:0] stDataWrite   = 3'd4;
    localparam logic [2:0] stHalt        = 3'd5;

    logic [2:0]              state;
    logic                    awaitData;
    logic [busAddrWidth-1:0] pc;
    logic [busAddrWidth-1:0] effAddr;
    logic [busDataWidth-1:0] acc;
    logic [busDataWidth-1:0] opcodeReg;
    logic                    flagN, flagZ, flagC;
    opcodeWord               decodeIn;
    aluOp                    operation;
    addrMode                 mode;
    logic [busDataWidth-1:0] aluResult;
    logic                    aluCarry;
    logic [busDataWidth:0]   sum;
    logic                    executeNow;

    // While fetching, decode straight from the returning byte
    assign decodeIn = (state == stFetch) ? bus.rdata : opcodeReg;

    instructionDecoder instructionDecoder_inst (
        .opcode(decodeIn),
        .operation(operation),
        .mode(mode)
    );

    assign bus.request = enable & ~awaitData & (state != stHalt);
    assign bus.write   = (state == stDataWrite);
    assign bus.addr    = (state == stDataRead || state == stDataWrite) ? effAddr : pc;
    assign bus.wdata   = acc;
    assign halted      = (state == stHalt);

    assign sum = {1'b0, acc} + {1'b0, bus.rdata} + {{busDataWidth{1'b0}}, flagC};

    always_comb begin
        aluCarry = flagC;
        case (operation)
            opOra: aluResult = acc | bus.rdata;
            opAnd: aluResult = acc & bus.rdata;
            opEor: aluResult = acc ^ bus.rdata;
            opAdc: begin
                aluResult = sum[busDataWidth-1:0];
                aluCarry  = sum[busDataWidth];
            end
            default: aluResult = bus.rdata;
        endcase
    end

    assign executeNow = awaitData &
                        ((state == stOperandLow && mode == modeImmediate) ||
                         state == stDataRead);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= stFetch;
            awaitData <= 1'b0;
            pc        <= '0;
            acc       <= '0;
            flagN     <= 1'b0;
            flagZ     <= 1'b0;
            flagC     <= 1'b0;
        end else begin
            if (bus.request && bus.grant) begin
                if (bus.write) begin
                    state <= stFetch;
                end else begin
                    awaitData <= 1'b1;
                end
            end
            if (awaitData) begin
                awaitData <= 1'b0;
                case (state)
                    stFetch: begin
                        pc <= pc + 1'b1;
                        if (operation == opBrk) begin
                            state <= stHalt;
                        end else if (operation != opNop) begin
                            state <= stOperandLow;
                        end
                    end
                    stOperandLow: begin
                        pc    <= pc + 1'b1;
                        state <= (mode == modeAbsolute) ? stOperandHigh : stFetch;
                    end
                    stOperandHigh: begin
                        if (operation == opJmp) begin
                            pc    <= {bus.rdata, effAddr[7:0]};
                            state <= stFetch;
                        end else begin
                            pc    <= pc + 1'b1;
                            state <= (operation == opSta) ? stDataWrite : stDataRead;
                        end
                    end
                    stDataRead: state <= stFetch;
                    default: ;
                endcase
            end
            if (executeNow) begin
                acc   <= aluResult;
                flagN <= aluResult[busDataWidth-1];
                flagZ <= (aluResult == '0);
                flagC <= aluCarry;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (awaitData && state == stFetch) begin
            opcodeReg <= bus.rdata;
        end
        if (awaitData && state == stOperandLow) begin
            effAddr[7:0] <= bus.rdata;
        end
        if (awaitData && state == stOperandHigh) begin
            effAddr[busAddrWidth-1:8] <= bus.rdata;
        end
    end

endmodule

//--- hdl/blockCopier.sv
`timescale 1ns/1ps

module blockCopier import cpuPkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  logic [busAddrWidth-1:0] source,
    input  logic [busAddrWidth-1:0] destination,
    input  logic [7:0]              length,
    memBusIf.requester              bus,
    output logic                    busy
);

    logic                    writePhase;
    logic                    awaitData;
    logic [busAddrWidth-1:0] srcAddr;
    logic [busAddrWidth-1:0] dstAddr;
    logic [7:0]              remaining;
    logic [busDataWidth-1:0] dataByte;

    assign bus.request = busy & (remaining != '0) & ~awaitData;
    assign bus.write   = writePhase;
    assign bus.addr    = writePhase ? dstAddr : srcAddr;
    assign bus.wdata   = dataByte;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy       <= 1'b0;
            writePhase <= 1'b0;
            awaitData  <= 1'b0;
        end else if (!busy) begin
            busy       <= start;
            writePhase <= 1'b0;
            awaitData  <= 1'b0;
        end else if (remaining == '0) begin
            // Last write has landed, or nothing to copy
            busy <= 1'b0;
        end else begin
            if (bus.grant) begin
                writePhase <= 1'b0;
                awaitData  <= ~writePhase;
            end
            if (awaitData) begin
                awaitData  <= 1'b0;
                writePhase <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && start) begin
            srcAddr   <= source;
            dstAddr   <= destination;
            remaining <= length;
        end else if (bus.request && bus.grant && writePhase) begin
            srcAddr   <= srcAddr + 1'b1;
            dstAddr   <= dstAddr + 1'b1;
            remaining <= remaining - 1'b1;
        end
        if (awaitData) begin
            dataByte <= bus.rdata;
        end
    end

endmodule

//--- hdl/busArbiter.sv
`timescale 1ns/1ps

module busArbiter import cpuPkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    memBusIf.arbiter                hostBus,
    memBusIf.arbiter                copyBus,
    memBusIf.arbiter                cpuBus,
    output logic                    ramWrite,
    output logic [busAddrWidth-1:0] ramAddr,
    output logic [busDataWidth-1:0] ramWriteData,
    input  logic [busDataWidth-1:0] ramReadData
);

    logic hostOwnsRead;
    logic copyOwnsRead;
    logic cpuOwnsRead;

    // Host first, then copier, then core
    assign hostBus.grant = hostBus.request;
    assign copyBus.grant = copyBus.request & ~hostBus.request;
    assign cpuBus.grant  = cpuBus.request & ~hostBus.request & ~copyBus.request;

    always_comb begin
        ramWrite     = 1'b0;
        ramAddr      = cpuBus.addr;
        ramWriteData = cpuBus.wdata;
        if (hostBus.grant) begin
            ramWrite     = hostBus.write;
            ramAddr      = hostBus.addr;
            ramWriteData = hostBus.wdata;
        end else if (copyBus.grant) begin
            ramWrite     = copyBus.write;
            ramAddr      = copyBus.addr;
            ramWriteData = copyBus.wdata;
        end else if (cpuBus.grant) begin
            ramWrite = cpuBus.write;
        end
    end

    // Remember who read since the data comes back a cycle later
    always_ff @(posedge clk) begin
        if (reset) begin
            hostOwnsRead <= 1'b0;
            copyOwnsRead <= 1'b0;
            cpuOwnsRead  <= 1'b0;
        end else begin
            hostOwnsRead <= hostBus.grant & ~hostBus.write;
            copyOwnsRead <= copyBus.grant & ~copyBus.write;
            cpuOwnsRead  <= cpuBus.grant & ~cpuBus.write;
        end
    end

    assign hostBus.rdata = hostOwnsRead ? ramReadData : '0;
    assign copyBus.rdata = copyOwnsRead ? ramReadData : '0;
    assign cpuBus.rdata  = cpuOwnsRead ? ramReadData : '0;

endmodule

//--- hdl/sharedRam.sv
`timescale 1ns/1ps

module sharedRam import cpuPkg::*; #(
    parameter int ramAddrBits = 8
) (
    input  logic                    clk,
    input  logic                    ramWrite,
    input  logic [busAddrWidth-1:0] ramAddr,
    input  logic [busDataWidth-1:0] ramWriteData,
    output logic [busDataWidth-1:0] ramReadData
);

    logic [busDataWidth-1:0] memory [2**ramAddrBits];

    // Upper address bits are ignored, so addresses wrap
    always_ff @(posedge clk) begin
        if (ramWrite) begin
            memory[ramAddr[ramAddrBits-1:0]] <= ramWriteData;
        end
        ramReadData <= memory[ramAddr[ramAddrBits-1:0]];
    end

endmodule

//--- hdl/systemTop.sv
`timescale 1ns/1ps

module systemTop import cpuPkg::*; #(
    parameter int ramAddrBits = 8
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cpuEnable,
    input  logic                    hostWrite,
    input  logic                    hostRead,
    input  logic [busAddrWidth-1:0] hostAddr,
    input  logic [busDataWidth-1:0] hostWriteData,
    output logic [busDataWidth-1:0] hostReadData,
    input  logic                    copyStart,
    input  logic [busAddrWidth-1:0] copySource,
    input  logic [busAddrWidth-1:0] copyDest,
    input  logic [7:0]              copyLength,
    output logic                    copyBusy,
    output logic                    cpuHalted
);

    logic                    ramWrite;
    logic [busAddrWidth-1:0] ramAddr;
    logic [busDataWidth-1:0] ramWriteData;
    logic [busDataWidth-1:0] ramReadData;

    memBusIf hostBus ();
    memBusIf copyBus ();
    memBusIf cpuBus ();

    // Host strobes become a bus request that is always granted
    assign hostBus.request = hostWrite | hostRead;
    assign hostBus.write   = hostWrite;
    assign hostBus.addr    = hostAddr;
    assign hostBus.wdata   = hostWriteData;
    assign hostReadData    = hostBus.rdata;

    cpuCore cpuCore_inst (
        .clk(clk),
        .reset(reset),
        .enable(cpuEnable),
        .bus(cpuBus.requester),
        .halted(cpuHalted)
    );

    blockCopier blockCopier_inst (
        .clk(clk),
        .reset(reset),
        .start(copyStart),
        .source(copySource),
        .destination(copyDest),
        .length(copyLength),
        .bus(copyBus.requester),
        .busy(copyBusy)
    );

    busArbiter busArbiter_inst (
        .clk(clk),
        .reset(reset),
        .hostBus(hostBus.arbiter),
        .copyBus(copyBus.arbiter),
        .cpuBus(cpuBus.arbiter),
        .ramWrite(ramWrite),
        .ramAddr(ramAddr),
        .ramWriteData(ramWriteData),
        .ramReadData(ramReadData)
    );

    sharedRam #(
        .ramAddrBits(ramAddrBits)
    ) sharedRam_inst (
        .clk(clk),
        .ramWrite(ramWrite),
        .ramAddr(ramAddr),
        .ramWriteData(ramWriteData),
        .ramReadData(ramReadData)
    );

endmodule

//--- verification/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
    parameter int resetCycles = 4
) (
    input  logic restart,
    output logic clk,
    output logic reset
);

    logic [3:0] resetCount = 4'(resetCycles);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset held for resetCycles edges at start and after each restart
    always @(posedge clk) begin
        if (restart) begin
            resetCount <= 4'(resetCycles);
        end else if (resetCount != 4'd0) begin
            resetCount <= resetCount - 4'd1;
        end
    end

    assign reset = (resetCount != 4'd0);

endmodule

//--- verification/systemTb.sv
`timescale 1ns/1ps

module systemTb import cpuPkg::*; ();

    localparam int ramAddrBits     = 8;
    localparam int ramBytes        = 2 ** ramAddrBits;
    localparam int programRuns     = 4;
    localparam int jumpRuns        = 2;
    localparam int copyRuns        = 6;
    localparam int maxProgramBytes = 64;
    localparam int maxCopyLength   = 16;
    localparam int runCount        = programRuns + jumpRuns + 1;
    localparam int hostAccesses    = ramBytes * (2 + runCount + copyRuns)
                                     + runCount * maxProgramBytes + 64;
    localparam int watchdogCycles  = 20 * runCount * maxProgramBytes
                                     + 6 * maxCopyLength * (copyRuns + 1)
                                     + 2 * hostAccesses + 2000;

    logic                    clk;
    logic                    reset;
    logic                    resetRequest;
    logic                    cpuEnable;
    logic                    hostWrite;
    logic                    hostRead;
    logic [busAddrWidth-1:0] hostAddr;
    logic [busDataWidth-1:0] hostWriteData;
    logic [busDataWidth-1:0] hostReadData;
    logic                    copyStart;
    logic [busAddrWidth-1:0] copySource;
    logic [busAddrWidth-1:0] copyDest;
    logic [7:0]              copyLength;
    logic                    copyBusy;
    logic                    cpuHalted;

    logic [31:0]             lcgState;
    logic [busDataWidth-1:0] modelMem [ramBytes];
    logic [busDataWidth-1:0] modelAcc;
    logic                    modelCarry;
    logic [busDataWidth-1:0] progBytes [$];
    int                      byteErrors;
    int                      flagErrors;
    int                      timeoutErrors;

    clockGen clockGen_inst (
        .restart(resetRequest),
        .clk(clk),
        .reset(reset)
    );

    systemTop #(
        .ramAddrBits(ramAddrBits)
    ) systemTop_inst (
        .clk(clk),
        .reset(reset),
        .cpuEnable(cpuEnable),
        .hostWrite(hostWrite),
        .hostRead(hostRead),
        .hostAddr(hostAddr),
        .hostWriteData(hostWriteData),
        .hostReadData(hostReadData),
        .copyStart(copyStart),
        .copySource(copySource),
        .copyDest(copyDest),
        .copyLength(copyLength),
        .copyBusy(copyBusy),
        .cpuHalted(cpuHalted)
    );

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return {8'b0, lcgState[31:8]};
    endfunction

    task automatic checkByte(input logic [busDataWidth-1:0] actual,
                             input logic [busDataWidth-1:0] expected, input string what);
        if (actual !== expected) begin
            byteErrors++;
            $display("FAILED at %0t: %s is %02h, expected %02h", $time, what, actual, expected);
        end
    endtask

    task automatic checkFlag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            flagErrors++;
            $display("FAILED at %0t: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    // Opcode bytes from the 6502 table
    function automatic logic [7:0] encodeOp(input aluOp op, input logic immediate);
        case (op)
            opOra:   return immediate ? 8'h09 : 8'h0D;
            opAnd:   return immediate ? 8'h29 : 8'h2D;
            opEor:   return immediate ? 8'h49 : 8'h4D;
            opAdc:   return immediate ? 8'h69 : 8'h6D;
            opLda:   return immediate ? 8'hA9 : 8'hAD;
            default: return 8'h8D;
        endcase
    endfunction

    function automatic logic inSubset(input logic [7:0] value);
        case (value)
            8'h00, 8'h4C, 8'h09, 8'h0D, 8'h29, 8'h2D, 8'h49, 8'h4D,
            8'h69, 8'h6D, 8'h8D, 8'hA9, 8'hAD: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [busDataWidth-1:0] memAt(input logic [busAddrWidth-1:0] addr);
        return modelMem[addr[ramAddrBits-1:0]];
    endfunction

    task automatic applyAlu(input logic [7:0] opcode, input logic [busDataWidth-1:0] operand);
        logic [busDataWidth:0] sum;
        sum = modelAcc;
        sum = sum + operand + modelCarry;
        case (opcode[7:4])
            4'h0: modelAcc = modelAcc | operand;
            4'h2: modelAcc = modelAcc & operand;
            4'h4: modelAcc = modelAcc ^ operand;
            4'h6: begin
                modelAcc   = sum[busDataWidth-1:0];
                modelCarry = sum[busDataWidth];
            end
            default: modelAcc = operand;
        endcase
    endtask

    // Executes the loaded program from address 0 until BRK
    task automatic runModel();
        logic [busAddrWidth-1:0] pc;
        logic [busAddrWidth-1:0] target;
        logic [7:0]              opcode;
        logic                    done;
        int                      steps;
        pc = '0;
        modelAcc = '0;
        modelCarry = 1'b0;
        done = 1'b0;
        steps = 0;
        while (!done && steps < 256) begin
            opcode = memAt(pc);
            target = {memAt(pc + 16'd2), memAt(pc + 16'd1)};
            steps++;
            case (opcode)
                8'h00: done = 1'b1;
                8'h4C: pc = target;
                8'h09, 8'h29, 8'h49, 8'h69, 8'hA9: begin
                    applyAlu(opcode, memAt(pc + 16'd1));
                    pc = pc + 16'd2;
                end
                8'h0D, 8'h2D, 8'h4D, 8'h6D, 8'hAD: begin
                    applyAlu(opcode, memAt(target));
                    pc = pc + 16'd3;
                end
                8'h8D: begin
                    modelMem[target[ramAddrBits-1:0]] = modelAcc;
                    pc = pc + 16'd3;
                end
                // Anything else is a one-byte no-op
                default: pc = pc + 16'd1;
            endcase
        end
        if (!done) begin
            timeoutErrors++;
            $display("Reference model ran 256 steps without reaching BRK");
        end
    endtask

    task automatic hostWriteByte(input logic [busAddrWidth-1:0] addr,
                                 input logic [busDataWidth-1:0] data);
        @(posedge clk);
        hostWrite     <= 1'b1;
        hostAddr      <= addr;
        hostWriteData <= data;
        @(posedge clk);
        hostWrite <= 1'b0;
    endtask

    // Data is sampled in the cycle right after the strobe
    task automatic hostReadByte(input logic [busAddrWidth-1:0] addr,
                                output logic [busDataWidth-1:0] data);
        @(posedge clk);
        hostRead <= 1'b1;
        hostAddr <= addr;
        @(posedge clk);
        hostRead <= 1'b0;
        @(negedge clk);
        data = hostReadData;
    endtask

    task automatic checkRam(input string label);
        logic [busDataWidth-1:0] data;
        for (int a = 0; a < ramBytes; a++) begin
            hostReadByte(busAddrWidth'(a), data);
            checkByte(data, modelMem[a], $sformatf("%s RAM[%02h]", label, a));
        end
    endtask

    task automatic restartCore();
        @(posedge clk);
        resetRequest <= 1'b1;
        @(posedge clk);
        resetRequest <= 1'b0;
        do @(negedge clk); while (reset);
        checkFlag(copyBusy, 1'b0, "copyBusy after reset");
        checkFlag(cpuHalted, 1'b0, "cpuHalted after reset");
    endtask

    task automatic emitInstruction();
        int   pick;
        aluOp op;
        logic immediate;
        pick = int'(nextRandom() % 8);
        // Extra weight on STA as the only visible result
        op = (pick < 6) ? aluOp'(pick) : opSta;
        immediate = (op != opSta) && (nextRandom() % 2 == 1);
        progBytes.push_back(encodeOp(op, immediate));
        if (immediate) begin
            progBytes.push_back(8'(nextRandom()));
        end else begin
            progBytes.push_back(8'h80 + 8'(nextRandom() % 64));
            progBytes.push_back(8'(nextRandom()));
        end
    endtask

    task automatic buildProgram(input int count);
        progBytes.delete();
        repeat (count) emitInstruction();
        progBytes.push_back(8'h00);
    endtask

    task automatic buildJumpProgram();
        int         skip;
        logic [7:0] filler;
        progBytes.delete();
        repeat (1 + nextRandom() % 3) emitInstruction();
        skip = int'(2 + nextRandom() % 4);
        progBytes.push_back(8'h4C);
        progBytes.push_back(8'(progBytes.size() + 5 + skip));
        progBytes.push_back(8'(nextRandom()));
        // Jumped-over bytes ending in a store that must not happen
        repeat (skip) progBytes.push_back(8'(nextRandom()));
        progBytes.push_back(8'h8D);
        progBytes.push_back(8'h80 + 8'(nextRandom() % 64));
        progBytes.push_back(8'(nextRandom()));
        repeat (4 + nextRandom() % 3) begin
            repeat (nextRandom() % 3) begin
                do filler = 8'(nextRandom()); while (inSubset(filler));
                progBytes.push_back(filler);
            end
            emitInstruction();
        end
        progBytes.push_back(8'h00);
    endtask

    task automatic loadProgram();
        for (int i = 0; i < progBytes.size(); i++) begin
            modelMem[i] = progBytes[i];
            hostWriteByte(busAddrWidth'(i), progBytes[i]);
        end
    endtask

    task automatic waitHalted();
        int cycles = 0;
        while (!cpuHalted && cycles < 20 * maxProgramBytes + 200) begin
            @(negedge clk);
            cycles++;
        end
        if (!cpuHalted) begin
            timeoutErrors++;
            $display("Timeout: the core did not halt within %0d cycles", cycles);
        end
    endtask

    task automatic startCopy(input logic [busAddrWidth-1:0] src,
                             input logic [busAddrWidth-1:0] dst, input logic [7:0] len);
        logic [busAddrWidth-1:0] from;
        logic [busAddrWidth-1:0] to;
        @(posedge clk);
        copyStart  <= 1'b1;
        copySource <= src;
        copyDest   <= dst;
        copyLength <= len;
        @(posedge clk);
        copyStart <= 1'b0;
        @(negedge clk);
        checkFlag(copyBusy, 1'b1, "copyBusy after copyStart");
        for (int i = 0; i < int'(len); i++) begin
            from = src + busAddrWidth'(i);
            to   = dst + busAddrWidth'(i);
            modelMem[to[ramAddrBits-1:0]] = modelMem[from[ramAddrBits-1:0]];
        end
    endtask

    task automatic waitCopyDone();
        int cycles = 0;
        while (copyBusy && cycles < 6 * maxCopyLength + 200) begin
            @(negedge clk);
            cycles++;
        end
        if (copyBusy) begin
            timeoutErrors++;
            $display("Timeout: the block copy was still busy after %0d cycles", cycles);
        end
    endtask

    function automatic logic [busAddrWidth-1:0] copyAddr(input logic [7:0] base);
        return {8'(nextRandom()), base + 8'(nextRandom() % 16)};
    endfunction

    initial begin
        logic [busDataWidth-1:0] value;
        logic [busAddrWidth-1:0] addr;
        int                      readsDuringCopy;
        cpuEnable     = 1'b0;
        hostWrite     = 1'b0;
        hostRead      = 1'b0;
        hostAddr      = '0;
        hostWriteData = '0;
        copyStart     = 1'b0;
        copySource    = '0;
        copyDest      = '0;
        copyLength    = '0;
        resetRequest  = 1'b0;
        lcgState      = 32'h7fc2_0f5b;
        byteErrors    = 0;
        flagErrors    = 0;
        timeoutErrors = 0;

        do @(negedge clk); while (reset);
        checkFlag(copyBusy, 1'b0, "copyBusy after reset");
        checkFlag(cpuHalted, 1'b0, "cpuHalted after reset");

        // Fill the whole RAM with random upper address bits to exercise wrapping
        for (int a = 0; a < ramBytes; a++) begin
            value = 8'(nextRandom());
            modelMem[a] = value;
            hostWriteByte({8'(nextRandom()), 8'(a)}, value);
        end
        checkRam("host fill");

        repeat (programRuns) begin
            restartCore();
            buildProgram(int'(6 + nextRandom() % 7));
            loadProgram();
            runModel();
            @(posedge clk);
            cpuEnable <= 1'b1;
            waitHalted();
            @(posedge clk);
            cpuEnable <= 1'b0;
            checkRam("program");
        end

        repeat (jumpRuns) begin
            restartCore();
            buildJumpProgram();
            loadProgram();
            runModel();
            @(posedge clk);
            cpuEnable <= 1'b1;
            waitHalted();
            @(posedge clk);
            cpuEnable <= 1'b0;
            checkRam("jump program");
        end

        // Source in C0..DF and destination in E0..FF never overlap
        for (int i = 0; i < copyRuns; i++) begin
            startCopy(copyAddr(8'hC0), copyAddr(8'hE0),
                      (i == 0) ? 8'd0 : 8'(nextRandom() % (maxCopyLength + 1)));
            waitCopyDone();
            checkRam("block copy");
        end

        // Copy and core together while host reads still return next cycle
        restartCore();
        buildProgram(10);
        loadProgram();
        runModel();
        @(posedge clk);
        cpuEnable <= 1'b1;
        startCopy(copyAddr(8'hC0), copyAddr(8'hE0), 8'(maxCopyLength));
        readsDuringCopy = 0;
        while (copyBusy && readsDuringCopy < 64) begin
            addr = busAddrWidth'(nextRandom() % progBytes.size());
            hostReadByte(addr, value);
            checkByte(value, memAt(addr), $sformatf("read during copy RAM[%02h]", addr));
            readsDuringCopy++;
        end
        checkFlag(readsDuringCopy != 0, 1'b1, "host reads issued during copyBusy");
        waitCopyDone();
        waitHalted();
        @(posedge clk);
        cpuEnable <= 1'b0;
        checkRam("concurrent");

        $display("Summary: %0d byte errors, %0d flag errors, %0d timeouts",
                 byteErrors, flagErrors, timeoutErrors);
        if (byteErrors + flagErrors + timeoutErrors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not complete", watchdogCycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- src.f
hdl/cpuPkg.sv
hdl/memBusIf.sv
hdl/instructionDecoder.sv
hdl/cpuCore.sv
hdl/blockCopier.sv
hdl/busArbiter.sv
hdl/sharedRam.sv
hdl/systemTop.sv
verification/clockGen.sv
verification/systemTb.sv

//--- run.sh
#!/bin/sh
# Compile and run the systemTb simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module systemTb -Mdir obj_dir -o simv
./obj_dir/simv | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1
